/* src/cache_tag_pkg.sv */
`default_nettype none

package cache_tag_pkg;

   // cache geometry
   localparam int addr_width   = 32;
   localparam int set_count    = 128;
   localparam int index_width  = 7;
   localparam int tag_width    = 21;
   localparam int offset_width = 4;
   localparam int way_count    = 2;

   // byte address fields, offset at the bottom
   localparam int index_lsb = offset_width;
   localparam int tag_lsb   = offset_width + index_width;

   // set entry layout {lru, valid1, tag1, valid0, tag0}
   localparam int entry_width = 2 * tag_width + 3;
   localparam int tag0_lsb    = 0;
   localparam int valid0_bit  = tag_width;
   localparam int tag1_lsb    = tag_width + 1;
   localparam int valid1_bit  = 2 * tag_width + 1;
   // lru names the way to replace next
   localparam int lru_bit     = 2 * tag_width + 2;

   typedef logic [addr_width-1:0]  cache_addr_t;
   typedef logic [tag_width-1:0]   tag_t;
   typedef logic [index_width-1:0] set_index_t;
   typedef logic                   way_t;
   typedef logic [way_count-1:0]   way_mask_t;
   typedef logic [entry_width-1:0] set_entry_t;

   // controller states
   typedef enum logic [2:0] {
      init_wait,
      idle,
      compare,
      hit_update,
      refill_wait,
      refill_write
   } ctrl_state_t;

endpackage

`default_nettype wire

/* src/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_store (
   input  wire logic                       clk,
   input  wire logic                       cache_reset,
   input  wire cache_tag_pkg::set_index_t  raddr,
   input  wire cache_tag_pkg::set_index_t  waddr,
   input  wire cache_tag_pkg::way_mask_t   we,
   input  wire cache_tag_pkg::set_entry_t  din,
   input  wire logic                       refill,
   input  wire logic                       load_over,
   output cache_tag_pkg::set_entry_t       dout,
   output logic                            init_busy
);
   import cache_tag_pkg::*;

   // tag arrays, one per way
   tag_t       tag_mem [way_count][set_count];
   // per set {lru, valid1, valid0}
   logic [2:0] flag_mem [set_count];

   // sweep counter for tag init
   set_index_t sweep_addr;
   // muxed and registered array address
   set_index_t mem_addr;
   set_index_t mem_addr_q;

   tag_t       din_tag [way_count];
   logic [2:0] din_flags;
   logic [2:0] flag_out;

   // split incoming entry into per-way tags
   assign din_tag[0] = din[tag0_lsb +: tag_width];
   assign din_tag[1] = din[tag1_lsb +: tag_width];
   // flag bits in the same order as flag_mem
   assign din_flags = {din[lru_bit], din[valid1_bit], din[valid0_bit]};

   // sweep wins, then write address, then read address
   assign mem_addr = init_busy            ? sweep_addr :
                     (refill | load_over) ? waddr      :
                                            raddr;

   // read address held for one cycle
   always_ff @(posedge clk) begin
      mem_addr_q <= mem_addr;
   end

   // init sweep over all sets after reset release
   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         sweep_addr <= '0;
         init_busy  <= 1'b1;
      end else if (init_busy) begin
         sweep_addr <= sweep_addr + set_index_t'(1);
         // last set written this cycle
         if (sweep_addr == set_index_t'(set_count - 1)) begin
            init_busy <= 1'b0;
         end
      end
   end

   // tag arrays
   always_ff @(posedge clk) begin
      for (int w = 0; w < way_count; w++) begin
         if (init_busy) begin
            // zero tags during sweep
            tag_mem[w][mem_addr] <= '0;
         end else if (we[w]) begin
            tag_mem[w][mem_addr] <= din_tag[w];
         end
      end
   end

   // valid and lru bits
   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         // all sets invalid in one cycle
         for (int s = 0; s < set_count; s++) begin
            flag_mem[s] <= 3'b000;
         end
      end else begin
         // valid bit follows its way enable
         for (int w = 0; w < way_count; w++) begin
            if (we[w]) begin
               flag_mem[mem_addr][w] <= din_flags[w];
            end
         end
         // lru rewritten on any way write
         if (|we) begin
            flag_mem[mem_addr][2] <= din_flags[2];
         end
      end
   end

   // read out at the registered address
   assign flag_out = flag_mem[mem_addr_q];
   assign dout     = {flag_out[2], flag_out[1], tag_mem[1][mem_addr_q],
                      flag_out[0], tag_mem[0][mem_addr_q]};

endmodule

`default_nettype wire

/* src/tag_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_lookup (
   input  wire cache_tag_pkg::set_entry_t  dout,
   input  wire cache_tag_pkg::tag_t        req_tag,
   output logic                            hit,
   output cache_tag_pkg::way_t             hit_way,
   output cache_tag_pkg::way_t             victim_way
);
   import cache_tag_pkg::*;

   // unpacked entry fields
   tag_t tag0;
   tag_t tag1;
   logic valid0;
   logic valid1;
   logic lru;

   // per way match
   logic match0;
   logic match1;

   assign tag0   = dout[tag0_lsb +: tag_width];
   assign tag1   = dout[tag1_lsb +: tag_width];
   assign valid0 = dout[valid0_bit];
   assign valid1 = dout[valid1_bit];
   assign lru    = dout[lru_bit];

   // match needs valid and equal tag
   assign match0 = valid0 && (tag0 == req_tag);
   assign match1 = valid1 && (tag1 == req_tag);

   assign hit = match0 | match1;
   // both ways matching never happens
   // refill only fills the miss victim
   assign hit_way = match1;

   // victim choice
   always_comb begin
      if (!valid0) begin
         // empty way 0 first
         victim_way = 1'b0;
      end else if (!valid1) begin
         victim_way = 1'b1;
      end else begin
         // set full, follow lru
         victim_way = lru;
      end
   end

endmodule

`default_nettype wire

/* src/tag_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_controller (
   input  wire logic                       clk,
   input  wire logic                       cache_reset,
   input  wire logic                       req,
   input  wire cache_tag_pkg::cache_addr_t addr,
   input  wire logic                       refill_done,
   input  wire logic                       init_busy,
   input  wire cache_tag_pkg::set_entry_t  dout,
   input  wire logic                       lookup_hit,
   input  wire cache_tag_pkg::way_t        lookup_way,
   input  wire cache_tag_pkg::way_t        lookup_victim,
   output cache_tag_pkg::set_index_t       raddr,
   output cache_tag_pkg::set_index_t       waddr,
   output cache_tag_pkg::way_mask_t        we,
   output cache_tag_pkg::set_entry_t       din,
   output logic                            refill,
   output logic                            load_over,
   output cache_tag_pkg::tag_t             req_tag,
   output logic                            ready,
   output logic                            done,
   output logic                            hit,
   output cache_tag_pkg::way_t             hit_way,
   output cache_tag_pkg::way_t             victim_way
);
   import cache_tag_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_next;

   // held request index
   set_index_t  req_index;
   // way written on hit update or refill
   way_t        target_way;
   set_entry_t  entry_new;

   // state register
   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         state <= init_wait;
      end else begin
         state <= state_next;
      end
   end

   // next state
   always_comb begin
      state_next = state;
      case (state)
         init_wait:    if (!init_busy) state_next = idle;
         idle:         if (req) state_next = compare;
         // lookup results valid here
         compare:      state_next = lookup_hit ? hit_update : refill_wait;
         hit_update:   state_next = idle;
         // wait as long as the line takes
         refill_wait:  if (refill_done) state_next = refill_write;
         refill_write: state_next = idle;
         default:      state_next = init_wait;
      endcase
   end

   // capture request fields when accepted
   always_ff @(posedge clk) begin
      if (state == idle && req) begin
         req_tag   <= addr[tag_lsb +: tag_width];
         req_index <= addr[index_lsb +: index_width];
      end
   end

   // lookup results registered at end of compare
   always_ff @(posedge clk) begin
      if (state == compare) begin
         hit        <= lookup_hit;
         hit_way    <= lookup_way;
         victim_way <= lookup_victim;
      end
   end

   // one cycle done pulse
   always_ff @(posedge clk) begin
      if (!cache_reset) begin
         done <= 1'b0;
      end else begin
         done <= (state == compare);
      end
   end

   assign ready = (state == idle);

   // read the live index only while idle
   // otherwise keep the held set on the store output
   assign raddr = (state == idle) ? addr[index_lsb +: index_width] : req_index;
   assign waddr = req_index;

   assign load_over = (state == hit_update);
   assign refill    = (state == refill_write);

   assign target_way = refill ? victim_way : hit_way;

   // one way enable per write
   always_comb begin
      if (load_over || refill) begin
         we = target_way ? 2'b10 : 2'b01;
      end else begin
         we = 2'b00;
      end
   end

   // new entry, other way kept as read
   always_comb begin
      entry_new = dout;
      if (target_way) begin
         entry_new[tag1_lsb +: tag_width] = req_tag;
         entry_new[valid1_bit]            = 1'b1;
      end else begin
         entry_new[tag0_lsb +: tag_width] = req_tag;
         entry_new[valid0_bit]            = 1'b1;
      end
      // replace the other way next
      entry_new[lru_bit] = ~target_way;
   end

   assign din = entry_new;

endmodule

`default_nettype wire

/* src/cache_tag_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_top (
   input  wire logic                       clk,
   input  wire logic                       cache_reset,
   input  wire logic                       req,
   input  wire cache_tag_pkg::cache_addr_t addr,
   input  wire logic                       refill_done,
   output logic                            ready,
   output logic                            done,
   output logic                            hit,
   output cache_tag_pkg::way_t             hit_way,
   output cache_tag_pkg::way_t             victim_way
);
   import cache_tag_pkg::*;

   // controller to store
   wire set_index_t raddr;
   wire set_index_t waddr;
   wire way_mask_t  we;
   wire set_entry_t din;
   wire             refill;
   wire             load_over;

   // store outputs
   wire set_entry_t dout;
   wire             init_busy;

   // lookup path
   wire tag_t       req_tag;
   wire             lookup_hit;
   wire way_t       lookup_way;
   wire way_t       lookup_victim;

   tag_controller u_ctrl (
      .clk           (clk),
      .cache_reset   (cache_reset),
      .req           (req),
      .addr          (addr),
      .refill_done   (refill_done),
      .init_busy     (init_busy),
      .dout          (dout),
      .lookup_hit    (lookup_hit),
      .lookup_way    (lookup_way),
      .lookup_victim (lookup_victim),
      .raddr         (raddr),
      .waddr         (waddr),
      .we            (we),
      .din           (din),
      .refill        (refill),
      .load_over     (load_over),
      .req_tag       (req_tag),
      .ready         (ready),
      .done          (done),
      .hit           (hit),
      .hit_way       (hit_way),
      .victim_way    (victim_way)
   );

   tag_store u_store (
      .clk         (clk),
      .cache_reset (cache_reset),
      .raddr       (raddr),
      .waddr       (waddr),
      .we          (we),
      .din         (din),
      .refill      (refill),
      .load_over   (load_over),
      .dout        (dout),
      .init_busy   (init_busy)
   );

   // compare is purely combinational on the store output
   tag_lookup u_lookup (
      .dout       (dout),
      .req_tag    (req_tag),
      .hit        (lookup_hit),
      .hit_way    (lookup_way),
      .victim_way (lookup_victim)
   );

endmodule

`default_nettype wire

/* bench/cache_tag_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_asserts (
   input wire logic                     clk,
   input wire logic                     cache_reset,
   input wire logic                     ready,
   input wire logic                     done,
   input wire logic                     init_busy,
   input wire cache_tag_pkg::way_mask_t we
);

   // done is a single cycle pulse
   done_one_cycle: assert property (@(posedge clk) disable iff (!cache_reset)
      done |=> !done)
      else $error("done stayed high for more than one cycle");

   // writes only happen while busy
   no_write_when_ready: assert property (@(posedge clk) disable iff (!cache_reset)
      ready |-> (we == 2'b00))
      else $error("way write enable set while ready is high");

   // one way per write
   write_one_hot: assert property (@(posedge clk) disable iff (!cache_reset)
      (we != 2'b00) |-> $onehot(we))
      else $error("both way write enables set");

   // no lookups during the tag sweep
   busy_blocks_ready: assert property (@(posedge clk) disable iff (!cache_reset)
      init_busy |-> !ready)
      else $error("ready high while tag sweep is running");

endmodule

bind tag_controller cache_tag_asserts u_asserts (
   .clk         (clk),
   .cache_reset (cache_reset),
   .ready       (ready),
   .done        (done),
   .init_busy   (init_busy),
   .we          (we)
);

`default_nettype wire

/* bench/cache_tag_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_tb;
   import cache_tag_pkg::*;

   // dut ports
   logic        clk;
   logic        cache_reset;
   logic        req;
   cache_addr_t addr;
   logic        refill_done;
   logic        ready;
   logic        done;
   logic        hit;
   way_t        hit_way;
   way_t        victim_way;

   // one entry per test line
   string       name_q[$];
   cache_addr_t addr_q[$];
   logic        hit_q[$];
   way_t        way_q[$];
   way_t        victim_q[$];

   integer      seed;
   bit          tests_loaded = 1'b0;

   cache_tag_top uut (
      .clk         (clk),
      .cache_reset (cache_reset),
      .req         (req),
      .addr        (addr),
      .refill_done (refill_done),
      .ready       (ready),
      .done        (done),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way)
   );

   // 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("Regression failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_bit(input string test_name, input string field,
                            input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERR %s %s expected %0b actual %0b", test_name, field, expected, actual);
         stop_with_failure();
      end
   endtask

   task automatic check_way(input string test_name, input string field,
                            input way_t expected, input way_t actual);
      if (actual !== expected) begin
         $display("ERR %s %s expected %0d actual %0d", test_name, field, expected, actual);
         stop_with_failure();
      end
   endtask

   // parse test file, '#' lines are comments
   task automatic load_tests();
      integer      fd;
      integer      fields;
      string       line;
      string       test_name;
      logic [31:0] addr_val;
      integer      hit_val;
      integer      way_val;
      integer      victim_val;
      fd = $fopen("bench/cache_tag_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open bench/cache_tag_tests.txt");
         stop_with_failure();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#") begin
               fields = $sscanf(line, "%s %h %d %d %d",
                                test_name, addr_val, hit_val, way_val, victim_val);
               if (fields == 5) begin
                  name_q.push_back(test_name);
                  addr_q.push_back(addr_val);
                  hit_q.push_back(hit_val != 0);
                  way_q.push_back(way_val[0]);
                  victim_q.push_back(victim_val[0]);
               end else if (fields > 0) begin
                  $display("malformed line in test file: %s", line);
                  stop_with_failure();
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // outputs sampled on falling edges
   task automatic wait_for_ready();
      @(negedge clk);
      while (!ready) @(negedge clk);
   endtask

   task automatic wait_for_done();
      @(negedge clk);
      while (!done) @(negedge clk);
   endtask

   // refill after random delay of 0 to 7 cycles
   task automatic serve_refill(input cache_addr_t line_addr);
      int delay;
      delay = $unsigned($random(seed)) % 8;
      // stray req while busy, must be dropped
      @(posedge clk);
      req  <= 1'b1;
      addr <= ~line_addr;
      @(posedge clk);
      req <= 1'b0;
      repeat (delay) @(posedge clk);
      refill_done <= 1'b1;
      @(posedge clk);
      refill_done <= 1'b0;
   endtask

   task automatic run_lookup(input int idx);
      wait_for_ready();
      @(posedge clk);
      req  <= 1'b1;
      addr <= addr_q[idx];
      @(posedge clk);
      req <= 1'b0;
      wait_for_done();
      check_bit(name_q[idx], "hit", hit_q[idx], hit);
      // way checked on hit, victim on miss
      if (hit_q[idx]) begin
         check_way(name_q[idx], "hit_way", way_q[idx], hit_way);
      end else begin
         check_way(name_q[idx], "victim_way", victim_q[idx], victim_way);
         serve_refill(addr_q[idx]);
      end
   endtask

   // budget: init sweep plus a fixed slice per lookup
   initial begin
      wait (tests_loaded);
      repeat (400 + 30 * name_q.size()) @(posedge clk);
      $display("timeout: lookups did not complete within the cycle budget");
      stop_with_failure();
   end

   initial begin
      cache_reset <= 1'b0;
      req         <= 1'b0;
      addr        <= '0;
      refill_done <= 1'b0;
      seed = 57160;
      load_tests();
      tests_loaded = 1'b1;
      // reset low for 5 cycles
      repeat (5) @(posedge clk);
      cache_reset <= 1'b1;
      for (int i = 0; i < name_q.size(); i++) begin
         run_lookup(i);
      end
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/cache_tag_tests.txt */
# name  address(hex)  hit  hit_way  victim_way
# hit_way is checked on hits, victim_way on misses; lines run in order
a_first          00000850 0 0 0
a_refilled       00000850 1 0 0
b_first          00001050 0 0 1
b_refilled       00001050 1 1 0
a_offset         00000854 1 0 0
c_evicts_b       00001850 0 0 1
a_survives       00000850 1 0 0
c_refilled       00001850 1 1 0
b_evicts_a       00001050 0 0 0
a_evicts_c       00000850 0 0 1
b_in_way0        0000105c 1 0 0
a_in_way1        0000085f 1 1 0
# tag zero is swept in but not valid
zero_tag         00000090 0 0 0
zero_tag_hit     0000009c 1 0 0
# same tag in other sets
same_tag_set6    00000860 0 0 0
same_tag_set0    00000800 0 0 0
set0_hit         00000808 1 0 0
set127_first     00000ff0 0 0 0
set127_hit       00000ff8 1 0 0
set127_high      fffffff0 0 0 1
set127_high_hit  ffffffff 1 1 0
set6_hit         00000864 1 0 0
set5_b_kept      00001050 1 0 0
d_evicts_a       00002050 0 0 1
a_gone           00000850 0 0 0

/* cache_tag.f */
src/cache_tag_pkg.sv
src/tag_store.sv
src/tag_lookup.sv
src/tag_controller.sv
src/cache_tag_top.sv
bench/cache_tag_asserts.sv
bench/cache_tag_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module cache_tag_tb -f cache_tag.f -o cache_tag_sim
./obj_dir/cache_tag_sim
